//--- pwl_stream_pkg.sv
package pwl_stream_pkg;

	localparam int SAMPLE_WIDTH = 16;
	localparam int BATCH_SIZE = 4; // Samples per DAC clock.

	typedef logic [SAMPLE_WIDTH-1:0] sample_t;

	// One PWL segment.
	typedef struct packed {
		sample_t x; // Start value.
		sample_t slope; // Step per sample.
		sample_t dt; // Length in samples.
	} segment_t;

	// Input stream beat.
	typedef struct packed {
		segment_t seg;
		logic last; // Ends the segment list.
	} stream_beat_t;

	// Sample 0 sits in the low bits.
	typedef sample_t [BATCH_SIZE-1:0] batch_t;

endpackage

//--- pwl_ctrl_pkg.sv
package pwl_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		READY,
		FETCH,
		EXPAND,
		DRAIN
	} gen_state_t;

	// Request into the interpolater.
	typedef struct packed {
		logic valid;
		pwl_stream_pkg::sample_t x; // Batch start value.
		pwl_stream_pkg::sample_t slope;
	} intrp_req_t;

endpackage

//--- segment_store.sv
module segment_store #(
	parameter int SEG_DEPTH = 16
) (
	input logic clk,
	input logic rst,
	input logic clear,
	input logic wr_en,
	input pwl_stream_pkg::segment_t wr_data,
	input logic rd_next,
	input logic stall,
	output pwl_stream_pkg::segment_t rd_data,
	output logic rd_valid,
	output logic full,
	output logic [$clog2(SEG_DEPTH):0] count
);
	localparam int AW = $clog2(SEG_DEPTH);

	pwl_stream_pkg::segment_t mem [SEG_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] wr_addr;
	logic [AW-1:0] rd_ptr;
	logic rd_wrap;

	assign wr_addr = clear ? '0 : wr_ptr; // A clearing write lands at 0.
	assign full = (count == SEG_DEPTH);
	assign rd_wrap = ({1'b0, rd_ptr} == count - 1'b1); // Last stored segment.

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			count <= '0;
		end else if (clear) begin
			wr_ptr <= AW'(wr_en);
			count <= {{AW{1'b0}}, wr_en};
		end else if (wr_en) begin
			wr_ptr <= wr_ptr + 1'b1;
			count <= count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || clear) begin
			rd_ptr <= '0;
			rd_valid <= 1'b0;
		end else if (!stall) begin
			rd_valid <= rd_next;
			if (rd_next) begin
				rd_ptr <= rd_wrap ? '0 : rd_ptr + 1'b1; // Loop over the list.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_next && !stall) begin
			rd_data <= mem[rd_ptr];
		end
	end

endmodule

//--- interpolater.sv
module interpolater (
	input logic clk,
	input logic rst,
	input logic en,
	input pwl_ctrl_pkg::intrp_req_t req,
	output pwl_stream_pkg::batch_t batch,
	output logic batch_valid
);
	pwl_stream_pkg::batch_t mult_q; // Slope times sample index.
	pwl_stream_pkg::sample_t x_q;
	logic valid_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
			batch_valid <= 1'b0;
		end else if (en) begin
			valid_q <= req.valid;
			batch_valid <= valid_q;
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			x_q <= req.x;
			for (int i = 0; i < pwl_stream_pkg::BATCH_SIZE; i++) begin
				mult_q[i] <= pwl_stream_pkg::sample_t'(req.slope * i);
			end
		end
	end

	// Second stage adds the start value to each multiple.
	always_ff @(posedge clk) begin
		if (en) begin
			for (int i = 0; i < pwl_stream_pkg::BATCH_SIZE; i++) begin
				batch[i] <= x_q + mult_q[i]; // Wraps mod 2^16.
			end
		end
	end

endmodule

//--- pwl_generator.sv
module pwl_generator #(
	parameter int SEG_DEPTH = 16
) (
	input logic clk,
	input logic rst,
	input logic run,
	input logic halt,
	input pwl_stream_pkg::stream_beat_t s_beat,
	input logic s_valid,
	output logic s_ready,
	input logic batch_ready,
	output logic rdy_to_run,
	output pwl_stream_pkg::batch_t batch,
	output logic batch_valid
);
	pwl_ctrl_pkg::gen_state_t state;
	pwl_ctrl_pkg::intrp_req_t req;
	pwl_stream_pkg::segment_t rd_data;
	pwl_stream_pkg::sample_t cur_x;
	pwl_stream_pkg::sample_t cur_slope;
	pwl_stream_pkg::sample_t dt_left; // Samples left in this segment.
	logic [$clog2(SEG_DEPTH):0] count;
	logic [1:0] in_flight; // Requests inside the interpolater.
	logic en;
	logic accept;
	logic clear;
	logic full;
	logic ends_list;
	logic rd_next;
	logic rd_valid;
	logic last_batch;

	assign en = batch_ready; // Sink back-pressure stalls replay.
	assign s_ready = (state == pwl_ctrl_pkg::IDLE) || (state == pwl_ctrl_pkg::LOAD && !full);
	assign accept = s_valid && s_ready;
	assign clear = accept && (state == pwl_ctrl_pkg::IDLE); // New list drops the old one.
	assign ends_list = s_beat.last || (state == pwl_ctrl_pkg::LOAD && count == SEG_DEPTH - 1);
	assign last_batch = (dt_left == pwl_stream_pkg::BATCH_SIZE);

	always_comb begin
		req.valid = (state == pwl_ctrl_pkg::EXPAND) && !halt;
		req.x = cur_x;
		req.slope = cur_slope;
		// Read ahead on the last batch of a segment.
		rd_next = !halt && ((state == pwl_ctrl_pkg::FETCH && !rd_valid) ||
			(state == pwl_ctrl_pkg::EXPAND && last_batch));
	end

	segment_store #(
		.SEG_DEPTH(SEG_DEPTH)
	) store0 (
		.clk(clk),
		.rst(rst),
		.clear(clear),
		.wr_en(accept),
		.wr_data(s_beat.seg),
		.rd_next(rd_next),
		.stall(!en),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.full(full),
		.count(count)
	);

	interpolater intrp0 (
		.clk(clk),
		.rst(rst),
		.en(en),
		.req(req),
		.batch(batch),
		.batch_valid(batch_valid)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= pwl_ctrl_pkg::IDLE;
			rdy_to_run <= 1'b0;
			in_flight <= '0;
		end else begin
			if (en) begin
				in_flight <= in_flight + 2'(req.valid) - 2'(batch_valid);
			end
			case (state)
				pwl_ctrl_pkg::IDLE: begin
					if (accept) begin
						rdy_to_run <= ends_list;
						state <= ends_list ? pwl_ctrl_pkg::READY : pwl_ctrl_pkg::LOAD;
					end
				end
				pwl_ctrl_pkg::LOAD: begin
					if (accept && ends_list) begin
						rdy_to_run <= 1'b1;
						state <= pwl_ctrl_pkg::READY;
					end
				end
				pwl_ctrl_pkg::READY: begin
					if (run) begin
						rdy_to_run <= 1'b0;
						state <= pwl_ctrl_pkg::FETCH;
					end
				end
				pwl_ctrl_pkg::FETCH: begin
					if (halt) begin
						state <= pwl_ctrl_pkg::DRAIN;
					end else if (en && rd_valid) begin
						state <= pwl_ctrl_pkg::EXPAND;
					end
				end
				pwl_ctrl_pkg::EXPAND: begin
					if (halt) begin
						state <= pwl_ctrl_pkg::DRAIN;
					end else if (en && last_batch) begin
						state <= pwl_ctrl_pkg::FETCH;
					end
				end
				pwl_ctrl_pkg::DRAIN: begin
					// Wait for the pipeline and any read ahead to empty.
					if (in_flight == 2'd0 && !rd_valid) begin
						rdy_to_run <= 1'b1;
						state <= pwl_ctrl_pkg::IDLE;
					end
				end
				default: state <= pwl_ctrl_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (en && state == pwl_ctrl_pkg::FETCH && rd_valid) begin
			cur_x <= rd_data.x;
			cur_slope <= rd_data.slope;
			dt_left <= rd_data.dt;
		end else if (en && req.valid) begin
			cur_x <= cur_x + pwl_stream_pkg::sample_t'(cur_slope * pwl_stream_pkg::BATCH_SIZE);
			dt_left <= dt_left - pwl_stream_pkg::sample_t'(pwl_stream_pkg::BATCH_SIZE);
		end
	end

endmodule

//--- pwl_top.sv
module pwl_top #(
	parameter int SEG_DEPTH = 16 // Segments held on chip.
) (
	input logic clk,
	input logic rst,
	input logic run,
	input logic halt,
	input pwl_stream_pkg::stream_beat_t s_beat,
	input logic s_valid,
	output logic s_ready,
	input logic batch_ready,
	output logic rdy_to_run,
	output pwl_stream_pkg::batch_t batch,
	output logic batch_valid
);

	pwl_generator #(
		.SEG_DEPTH(SEG_DEPTH)
	) gen0 (
		.clk(clk),
		.rst(rst),
		.run(run),
		.halt(halt),
		.s_beat(s_beat),
		.s_valid(s_valid),
		.s_ready(s_ready),
		.batch_ready(batch_ready),
		.rdy_to_run(rdy_to_run),
		.batch(batch),
		.batch_valid(batch_valid)
	);

endmodule

//--- tb_pwl.sv
module tb_pwl;
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic [7:0] kind; // S, R, H or B.
		pwl_stream_pkg::stream_beat_t beat;
		logic [15:0] n; // Batches to collect.
	} cmd_t;

	logic clk;
	logic rst;
	logic run;
	logic halt;
	pwl_stream_pkg::stream_beat_t s_beat;
	logic s_valid;
	logic s_ready;
	logic batch_ready;
	logic rdy_to_run;
	pwl_stream_pkg::batch_t batch;
	logic batch_valid;

	cmd_t cmds[$];
	pwl_stream_pkg::segment_t segs[$]; // Model copy of the loaded list.
	logic list_done;
	logic bp_random;
	int m_seg;
	int m_left;
	pwl_stream_pkg::sample_t m_x; // Start of the next expected batch.
	int seed;
	int n_checks;
	int n_errors;
	int n_batches;
	int wd_ns;

	pwl_top #(
		.SEG_DEPTH(16)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.run(run),
		.halt(halt),
		.s_beat(s_beat),
		.s_valid(s_valid),
		.s_ready(s_ready),
		.batch_ready(batch_ready),
		.rdy_to_run(rdy_to_run),
		.batch(batch),
		.batch_valid(batch_valid)
	);

	always #5 clk = ~clk;

	task automatic check_flag(input logic got, input logic exp, input string name);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERROR %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_batch(input pwl_stream_pkg::batch_t got,
			input pwl_stream_pkg::batch_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERROR %0t: batch %0d is %h, expected %h", $time, n_batches, got, exp);
		end
	endtask

	task automatic read_golden(output logic ok);
		int fd;
		int c;
		int code;
		int x;
		int slope;
		int dt;
		int last;
		cmd_t cmd;
		ok = 1'b0;
		fd = $fopen("pwl_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open pwl_golden.txt for reading");
		end else begin
			ok = 1'b1;
			c = $fgetc(fd);
			while (c != -1 && ok) begin
				cmd = '0;
				cmd.kind = c[7:0];
				if (c == "#") begin
					while (c != "\n" && c != -1) begin
						c = $fgetc(fd);
					end
				end else if (c == "S") begin
					code = $fscanf(fd, "%h %h %d %d", x, slope, dt, last);
					cmd.beat.seg = {x[15:0], slope[15:0], dt[15:0]};
					cmd.beat.last = last[0];
					ok = (code == 4);
					cmds.push_back(cmd);
				end else if (c == "R") begin
					code = $fscanf(fd, "%d", x);
					cmd.n = x[15:0];
					ok = (code == 1);
					cmds.push_back(cmd);
				end else if (c == "H" || c == "B") begin
					cmds.push_back(cmd);
				end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
					ok = 1'b0;
				end
				c = $fgetc(fd);
			end
			if (!ok) begin
				$display("Unreadable command in pwl_golden.txt");
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_ready();
		int rnd;
		if (bp_random) begin
			rnd = $random(seed);
			batch_ready = (rnd[1:0] != 2'b00); // Ready about 3 cycles in 4.
		end else begin
			batch_ready = 1'b1;
		end
	endtask

	// Expected batch from the PWL rule, then step to the next one.
	task automatic take_transfer();
		pwl_stream_pkg::batch_t exp_b;
		for (int i = 0; i < pwl_stream_pkg::BATCH_SIZE; i++) begin
			exp_b[i] = m_x + pwl_stream_pkg::sample_t'(segs[m_seg].slope * i);
		end
		check_batch(batch, exp_b);
		n_batches++;
		m_x = m_x + pwl_stream_pkg::sample_t'(segs[m_seg].slope * pwl_stream_pkg::BATCH_SIZE);
		m_left = m_left - pwl_stream_pkg::BATCH_SIZE;
		if (m_left <= 0) begin
			m_seg = (m_seg + 1) % segs.size(); // Loop back to the first.
			m_x = segs[m_seg].x;
			m_left = segs[m_seg].dt;
		end
	endtask

	task automatic send_beat(input pwl_stream_pkg::stream_beat_t b);
		if (list_done) begin
			segs.delete();
		end
		segs.push_back(b.seg);
		list_done = b.last;
		@(negedge clk);
		s_beat = b;
		s_valid = 1'b1;
		while (!s_ready) begin
			@(negedge clk);
		end
		@(negedge clk); // Taken on the rising edge in between.
		s_valid = 1'b0;
		check_flag(batch_valid, 1'b0, "batch_valid while loading");
		check_flag(rdy_to_run, b.last, "rdy_to_run after beat");
		if (b.last) begin
			check_flag(s_ready, 1'b0, "s_ready after last beat");
		end
	endtask

	task automatic pulse_run();
		m_seg = 0;
		m_x = segs[0].x;
		m_left = segs[0].dt;
		@(negedge clk);
		run = 1'b1;
		@(negedge clk);
		run = 1'b0;
		check_flag(rdy_to_run, 1'b0, "rdy_to_run after run");
	endtask

	task automatic collect_batches(input int n);
		int got;
		got = 0;
		while (got < n) begin
			@(negedge clk);
			drive_ready();
			if (batch_valid && batch_ready) begin
				take_transfer();
				got++;
			end
		end
		@(negedge clk);
		batch_ready = 1'b0; // Hold the pipeline.
	endtask

	task automatic halt_and_drain();
		int drained;
		drained = 0;
		@(negedge clk);
		halt = 1'b1;
		while (!rdy_to_run) begin
			drive_ready();
			if (batch_valid && batch_ready) begin
				take_transfer();
				drained++;
			end
			@(negedge clk);
		end
		halt = 1'b0;
		batch_ready = 1'b0;
		check_flag(drained <= 2, 1'b1, "no more than two batches after halt");
		check_flag(batch_valid, 1'b0, "batch_valid after drain");
		check_flag(s_ready, 1'b1, "s_ready after drain");
	endtask

	initial begin
		wait (wd_ns > 0);
		#(wd_ns);
		$display("Timeout: the run did not finish within %0d ns", wd_ns);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		logic ok;
		int total;
		clk = 1'b0;
		rst = 1'b1;
		run = 1'b0;
		halt = 1'b0;
		s_beat = '0;
		s_valid = 1'b0;
		batch_ready = 1'b0;
		list_done = 1'b1;
		bp_random = 1'b0;
		seed = 37218;
		n_checks = 0;
		n_errors = 0;
		n_batches = 0;
		wd_ns = 0;
		total = 0;
		read_golden(ok);
		if (!ok) begin
			n_errors++;
		end else begin
			foreach (cmds[i]) begin
				total += (cmds[i].kind == "R") ? int'(cmds[i].n) : 0;
			end
			wd_ns = (20 * total + 50 * cmds.size()) * 10; // 10 ns per cycle.
			repeat (3) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			check_flag(s_ready, 1'b1, "s_ready after reset");
			check_flag(rdy_to_run, 1'b0, "rdy_to_run after reset");
			check_flag(batch_valid, 1'b0, "batch_valid after reset");
			foreach (cmds[i]) begin
				case (cmds[i].kind)
					"S": send_beat(cmds[i].beat);
					"R": begin
						pulse_run();
						collect_batches(int'(cmds[i].n));
					end
					"H": halt_and_drain();
					"B": bp_random = 1'b1;
					default: ;
				endcase
			end
		end
		$display("Checks: %0d, errors: %0d, batches: %0d", n_checks, n_errors, n_batches);
		if (n_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- pwl_golden.txt
# S x slope dt last : load one segment (x and slope in hex, dt and last in decimal)
# R n : run and check n batches, H : halt and drain, B : random batch_ready from here on
S 0100 0010 8 0
S 2000 fff0 12 0
S 8000 0001 4 1
R 20
H
B
S 0000 0100 16 0
S fff0 0003 4 0
S 1234 8001 8 1
R 30
H
S 0100 0010 8 0
S 2000 fff0 12 0
S 8000 0001 4 1
R 20
H

//--- build.f
pwl_stream_pkg.sv
pwl_ctrl_pkg.sv
segment_store.sv
interpolater.sv
pwl_generator.sv
pwl_top.sv
tb_pwl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the PWL generator testbench with Verilator.
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_pwl -f build.f -o sim_pwl
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_pwl > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" "$log"; then
	echo "Testbench reported a failure"
	exit 1
fi
exit 0
